// File: Bender.yml
package:
  name: prf

sources:
  - source/prf_pkg.sv
  - source/prf_bank.sv
  - source/prf_read_arbiter.sv
  - source/prf_wb_arbiter.sv
  - source/prf_init_fsm.sv
  - source/prf.sv
  - source/prf_wrapper.sv
  - target: test
    files:
      - verif/prf_wrapper_chk.sv
      - verif/tb_prf_wrapper.sv

// File: compile.f
source/prf_pkg.sv
source/prf_bank.sv
source/prf_read_arbiter.sv
source/prf_wb_arbiter.sv
source/prf_init_fsm.sv
source/prf.sv
source/prf_wrapper.sv
verif/prf_wrapper_chk.sv
verif/tb_prf_wrapper.sv

// File: source/prf.sv
// prf core
// four banks with their read and write arbiters and the init sweep
// purely combinational apart from bank storage and arbiter state
`timescale 1ns/1ps

module prf (
	input  logic CLK,
	input  logic nRST,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0] read_req_valid_by_rr,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] read_req_PR_by_rr,
	output logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_ack_by_rr,
	output logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_port_by_rr,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::PRF_DATA_WIDTH-1:0]
		read_data_by_bank_by_port,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] WB_valid_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] WB_send_complete_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] WB_data_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] WB_PR_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_by_wr,
	output logic [prf_pkg::PRF_WR_COUNT-1:0] WB_ready_by_wr,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] WB_bus_upper_PR_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0]
		forward_data_bus_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0]
		complete_bus_ROB_index_by_bank
);

	logic init_active;
	logic init_we;
	logic [prf_pkg::LOG_PRF_ROWS-1:0] init_row;

	// read row select per bank and port
	logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::LOG_PRF_ROWS-1:0] rd_row_by_bank_by_port;

	// arbiter write side, before the sweep mux
	logic [prf_pkg::PRF_BANK_COUNT-1:0] wr_en_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] wr_row_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] wr_data_by_bank;

	prf_init_fsm i_init_fsm (.*);

	prf_read_arbiter i_read_arbiter (.*);

	prf_wb_arbiter i_wb_arbiter (.*);

	// --------------------------------------------------
	// banks, sweep write takes over while init runs
	for (genvar b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin : g_bank
		prf_bank i_bank (
			.CLK     (CLK),
			.we      (init_we | wr_en_by_bank[b]),
			.wr_row  (init_we ? init_row : wr_row_by_bank[b]),
			.wr_data (init_we ? '0 : wr_data_by_bank[b]),
			.rd_row  (rd_row_by_bank_by_port[b]),
			.rd_data (read_data_by_bank_by_port[b])
		);
	end

endmodule

// File: source/prf_bank.sv
// one register file bank
// 16 words, one write port on the clock edge, two async read ports
`timescale 1ns/1ps

module prf_bank (
	input  logic CLK,

	// write port
	input  logic we,
	input  logic [prf_pkg::LOG_PRF_ROWS-1:0] wr_row,
	input  logic [prf_pkg::PRF_DATA_WIDTH-1:0] wr_data,

	// read ports 0 and 1
	input  logic [1:0][prf_pkg::LOG_PRF_ROWS-1:0] rd_row,
	output logic [1:0][prf_pkg::PRF_DATA_WIDTH-1:0] rd_data
);

	// storage, contents undefined until the init sweep
	logic [prf_pkg::PRF_DATA_WIDTH-1:0] mem [prf_pkg::PRF_ROWS];

	// --------------------------------------------------
	// write
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[wr_row] <= wr_data;
		end
	end

	// --------------------------------------------------
	// reads see the array as of the last edge
	// same cycle write shows up on the next cycle only
	assign rd_data[0] = mem[rd_row[0]];
	assign rd_data[1] = mem[rd_row[1]];

endmodule

// File: source/prf_init_fsm.sv
// init sequencer
// zeroes one row of every bank per cycle after reset,
// holds off all grants until the sweep is done
`timescale 1ns/1ps

module prf_init_fsm (
	input  logic CLK,
	input  logic nRST,
	output logic init_active,
	output logic init_we,
	output logic [prf_pkg::LOG_PRF_ROWS-1:0] init_row
);

	logic state_q;

	// sweep row, wraps back to 0 on leaving SWEEP
	logic [prf_pkg::LOG_PRF_ROWS-1:0] row_q;

	// --------------------------------------------------
	// state and row counter
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= prf_pkg::PRF_INIT_SWEEP;
			row_q <= '0;
		end else if (state_q == prf_pkg::PRF_INIT_SWEEP) begin
			row_q <= row_q + 1'b1;
			// last row written on this edge
			if (row_q == (prf_pkg::LOG_PRF_ROWS)'(prf_pkg::PRF_ROWS - 1)) begin
				state_q <= prf_pkg::PRF_INIT_RUN;
			end
		end
	end

	// --------------------------------------------------
	// outputs
	// high for exactly PRF_ROWS cycles after reset release
	assign init_active = (state_q == prf_pkg::PRF_INIT_SWEEP);

	// one zero write per bank per sweep cycle
	assign init_we = init_active;
	assign init_row = row_q;

endmodule

// File: source/prf_pkg.sv
// prf sizing package
// register file geometry, requester counts, rob width and the
// register index view shared by the arbiters and the testbench model
package prf_pkg;

	// --------------------------------------------------
	// geometry
	localparam int PR_COUNT           = 64;
	localparam int LOG_PR_COUNT       = 6;
	localparam int PRF_BANK_COUNT     = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	localparam int PRF_ROWS           = 16;
	// row index, also the upper register bits
	localparam int LOG_PRF_ROWS       = 4;
	localparam int PRF_DATA_WIDTH     = 32;

	// --------------------------------------------------
	// requesters
	localparam int PRF_RR_COUNT     = 4;
	localparam int PRF_WR_COUNT     = 4;
	// width of the per bank round robin pointer
	localparam int LOG_PRF_WR_COUNT = 2;

	// rob index width
	localparam int ROB_ENTRIES     = 32;
	localparam int LOG_ROB_ENTRIES = 5;

	// init sequencer state encoding
	localparam logic PRF_INIT_SWEEP = 1'b0;
	localparam logic PRF_INIT_RUN   = 1'b1;

	// --------------------------------------------------
	// physical register number, raw or split into row and bank
	// bank sits in the low bits so p mod 4 picks the bank
	typedef union packed {
		logic [LOG_PR_COUNT-1:0] raw;
		struct packed {
			logic [LOG_PRF_ROWS-1:0]       upper;
			logic [LOG_PRF_BANK_COUNT-1:0] bank;
		} fields;
	} pr_index_u;

endpackage

// File: source/prf_read_arbiter.sv
// read port arbiter
// maps up to two requesters per bank onto that bank's read ports,
// lowest requester first, and returns ack and port per requester
`timescale 1ns/1ps

module prf_read_arbiter (
	input  logic init_active,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0] read_req_valid_by_rr,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] read_req_PR_by_rr,
	output logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_ack_by_rr,
	output logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_port_by_rr,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::LOG_PRF_ROWS-1:0]
		rd_row_by_bank_by_port
);

	// requests seen as bank and row
	prf_pkg::pr_index_u [prf_pkg::PRF_RR_COUNT-1:0] req_pr;

	// ports already handed out in this cycle
	logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0] port_taken;

	assign req_pr = read_req_PR_by_rr;

	// --------------------------------------------------
	// in order scan over requesters
	always_comb begin
		read_resp_ack_by_rr = '0;
		read_resp_port_by_rr = '0;
		// unused ports point at row 0
		rd_row_by_bank_by_port = '0;
		port_taken = '0;
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			// nothing acked while the sweep owns the banks
			if (read_req_valid_by_rr[rr] && !init_active) begin
				if (!port_taken[req_pr[rr].fields.bank][0]) begin
					// first hit on this bank takes port 0
					port_taken[req_pr[rr].fields.bank][0] = 1'b1;
					rd_row_by_bank_by_port[req_pr[rr].fields.bank][0] = req_pr[rr].fields.upper;
					read_resp_ack_by_rr[rr] = 1'b1;
					read_resp_port_by_rr[rr] = 1'b0;
				end else if (!port_taken[req_pr[rr].fields.bank][1]) begin
					// second hit takes port 1
					port_taken[req_pr[rr].fields.bank][1] = 1'b1;
					rd_row_by_bank_by_port[req_pr[rr].fields.bank][1] = req_pr[rr].fields.upper;
					read_resp_ack_by_rr[rr] = 1'b1;
					read_resp_port_by_rr[rr] = 1'b1;
				end
				// third and later hits get no ack and must retry
			end
		end
	end

endmodule

// File: source/prf_wb_arbiter.sv
// write-back arbiter
// round robin pick of one writer per bank; drives the bank write,
// the write-back, forward and complete buses and ready per writer
`timescale 1ns/1ps

module prf_wb_arbiter (
	input  logic CLK,
	input  logic nRST,
	input  logic init_active,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] WB_valid_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] WB_send_complete_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] WB_data_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] WB_PR_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_by_wr,
	output logic [prf_pkg::PRF_WR_COUNT-1:0] WB_ready_by_wr,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] wr_en_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] wr_row_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] wr_data_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] WB_bus_upper_PR_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0]
		forward_data_bus_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0]
		complete_bus_ROB_index_by_bank
);

	prf_pkg::pr_index_u [prf_pkg::PRF_WR_COUNT-1:0] wb_pr;

	// priority pointer per bank, next writer to favor
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_WR_COUNT-1:0] ptr_q, ptr_d;

	// winner per bank
	logic [prf_pkg::PRF_BANK_COUNT-1:0] grant;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_WR_COUNT-1:0] winner;

	assign wb_pr = WB_PR_by_wr;

	// --------------------------------------------------
	// rotating scan from the pointer
	always_comb begin
		logic [prf_pkg::LOG_PRF_WR_COUNT-1:0] w;
		grant = '0;
		winner = '0;
		for (int b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin
			for (int i = 0; i < prf_pkg::PRF_WR_COUNT; i++) begin
				w = ptr_q[b] + (prf_pkg::LOG_PRF_WR_COUNT)'(i);
				if (!grant[b] && !init_active && WB_valid_by_wr[w]
					&& wb_pr[w].fields.bank == (prf_pkg::LOG_PRF_BANK_COUNT)'(b)) begin
					grant[b] = 1'b1;
					winner[b] = w;
				end
			end
		end
	end

	// --------------------------------------------------
	// bank side and bus outputs, zero when idle
	always_comb begin
		WB_ready_by_wr = '0;
		ptr_d = ptr_q;
		wr_en_by_bank = grant;
		WB_bus_valid_by_bank = grant;
		wr_row_by_bank = '0;
		wr_data_by_bank = '0;
		complete_bus_valid_by_bank = '0;
		complete_bus_ROB_index_by_bank = '0;
		for (int b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin
			if (grant[b]) begin
				WB_ready_by_wr[winner[b]] = 1'b1;
				// winner drops to lowest priority
				ptr_d[b] = winner[b] + 1'b1;
				wr_row_by_bank[b] = wb_pr[winner[b]].fields.upper;
				wr_data_by_bank[b] = WB_data_by_wr[winner[b]];
				complete_bus_valid_by_bank[b] = WB_send_complete_by_wr[winner[b]];
				complete_bus_ROB_index_by_bank[b] = WB_ROB_index_by_wr[winner[b]];
			end
		end
	end

	// buses mirror the bank write
	assign WB_bus_upper_PR_by_bank = wr_row_by_bank;
	assign forward_data_bus_by_bank = wr_data_by_bank;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ptr_q <= '0;
		end else begin
			ptr_q <= ptr_d;
		end
	end

endmodule

// File: source/prf_wrapper.sv
// prf top level
// flops every input into the core and every core output to the pins
// fixed two cycle latency from request to result
`timescale 1ns/1ps

module prf_wrapper (
	input  logic CLK,
	input  logic nRST,

	// read requests by requester
	input  logic [prf_pkg::PRF_RR_COUNT-1:0] next_read_req_valid_by_rr,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] next_read_req_PR_by_rr,

	// read responses
	output logic [prf_pkg::PRF_RR_COUNT-1:0] last_read_resp_ack_by_rr,
	output logic [prf_pkg::PRF_RR_COUNT-1:0] last_read_resp_port_by_rr,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::PRF_DATA_WIDTH-1:0]
		last_read_data_by_bank_by_port,

	// write-back requests by writer
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] next_WB_valid_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] next_WB_send_complete_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] next_WB_data_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] next_WB_PR_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0]
		next_WB_ROB_index_by_wr,
	output logic [prf_pkg::PRF_WR_COUNT-1:0] last_WB_ready_by_wr,

	// buses by bank
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] last_WB_bus_valid_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0]
		last_WB_bus_upper_PR_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0]
		last_forward_data_bus_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0] last_complete_bus_valid_by_bank,
	output logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0]
		last_complete_bus_ROB_index_by_bank
);

	// --------------------------------------------------
	// core side signals, same names as the core ports
	logic [prf_pkg::PRF_RR_COUNT-1:0] read_req_valid_by_rr;
	logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] read_req_PR_by_rr;
	logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_ack_by_rr;
	logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_port_by_rr;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::PRF_DATA_WIDTH-1:0] read_data_by_bank_by_port;
	logic [prf_pkg::PRF_WR_COUNT-1:0] WB_valid_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0] WB_send_complete_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] WB_data_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] WB_PR_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] WB_ROB_index_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0] WB_ready_by_wr;
	logic [prf_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] WB_bus_upper_PR_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] forward_data_bus_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] complete_bus_ROB_index_by_bank;

	prf i_prf (.*);

	// --------------------------------------------------
	// input and output flops, all cleared on reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			read_req_valid_by_rr <= '0;
			read_req_PR_by_rr <= '0;
			WB_valid_by_wr <= '0;
			WB_send_complete_by_wr <= '0;
			WB_data_by_wr <= '0;
			WB_PR_by_wr <= '0;
			WB_ROB_index_by_wr <= '0;
			last_read_resp_ack_by_rr <= '0;
			last_read_resp_port_by_rr <= '0;
			last_read_data_by_bank_by_port <= '0;
			last_WB_ready_by_wr <= '0;
			last_WB_bus_valid_by_bank <= '0;
			last_WB_bus_upper_PR_by_bank <= '0;
			last_forward_data_bus_by_bank <= '0;
			last_complete_bus_valid_by_bank <= '0;
			last_complete_bus_ROB_index_by_bank <= '0;
		end else begin
			// inputs toward the core
			read_req_valid_by_rr <= next_read_req_valid_by_rr;
			read_req_PR_by_rr <= next_read_req_PR_by_rr;
			WB_valid_by_wr <= next_WB_valid_by_wr;
			WB_send_complete_by_wr <= next_WB_send_complete_by_wr;
			WB_data_by_wr <= next_WB_data_by_wr;
			WB_PR_by_wr <= next_WB_PR_by_wr;
			WB_ROB_index_by_wr <= next_WB_ROB_index_by_wr;
			// core results toward the pins
			last_read_resp_ack_by_rr <= read_resp_ack_by_rr;
			last_read_resp_port_by_rr <= read_resp_port_by_rr;
			last_read_data_by_bank_by_port <= read_data_by_bank_by_port;
			last_WB_ready_by_wr <= WB_ready_by_wr;
			last_WB_bus_valid_by_bank <= WB_bus_valid_by_bank;
			last_WB_bus_upper_PR_by_bank <= WB_bus_upper_PR_by_bank;
			last_forward_data_bus_by_bank <= forward_data_bus_by_bank;
			last_complete_bus_valid_by_bank <= complete_bus_valid_by_bank;
			last_complete_bus_ROB_index_by_bank <= complete_bus_ROB_index_by_bank;
		end
	end

endmodule

// File: verif/prf_wrapper_chk.sv
// prf wrapper assertions
// grant uniqueness, read port order, bus consistency and the init hold-off
`timescale 1ns/1ps

module prf_wrapper_chk (
	input  logic CLK,
	input  logic nRST,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_ack_by_rr,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0] read_resp_port_by_rr,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] read_req_PR_by_rr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] WB_ready_by_wr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] WB_PR_by_wr,
	input  logic [prf_pkg::PRF_RR_COUNT-1:0] last_read_resp_ack_by_rr,
	input  logic [prf_pkg::PRF_WR_COUNT-1:0] last_WB_ready_by_wr,
	input  logic [prf_pkg::PRF_BANK_COUNT-1:0] last_WB_bus_valid_by_bank,
	input  logic [prf_pkg::PRF_BANK_COUNT-1:0] last_complete_bus_valid_by_bank
);

	// writers aimed at each bank
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_WR_COUNT-1:0] wr_mask_by_bank;
	// port 0 handed out on the bank, per bank and seen from each requester
	logic [prf_pkg::PRF_BANK_COUNT-1:0] port0_used;
	logic [prf_pkg::PRF_RR_COUNT-1:0] port0_seen_by_rr;
	// saturating edge count since reset release
	logic [4:0] cycles_since_reset;

	always_comb begin
		prf_pkg::pr_index_u pr;
		wr_mask_by_bank = '0;
		port0_used = '0;
		for (int w = 0; w < prf_pkg::PRF_WR_COUNT; w++) begin
			pr = WB_PR_by_wr[w];
			wr_mask_by_bank[pr.fields.bank][w] = 1'b1;
		end
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			pr = read_req_PR_by_rr[rr];
			if (read_resp_ack_by_rr[rr] && !read_resp_port_by_rr[rr]) begin
				port0_used[pr.fields.bank] = 1'b1;
			end
		end
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			pr = read_req_PR_by_rr[rr];
			port0_seen_by_rr[rr] = port0_used[pr.fields.bank];
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			cycles_since_reset <= '0;
		end else if (cycles_since_reset != 5'd31) begin
			cycles_since_reset <= cycles_since_reset + 1'b1;
		end
	end

	// --------------------------------------------------
	// per bank and per requester properties
	for (genvar b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin : g_bank
		a_one_ready: assert property (@(posedge CLK) disable iff (!nRST)
			$countones(WB_ready_by_wr & wr_mask_by_bank[b]) <= 1)
			else $error("more than one writer granted on bank %0d", b);
		a_complete_in_wb: assert property (@(posedge CLK) disable iff (!nRST)
			last_complete_bus_valid_by_bank[b] |-> last_WB_bus_valid_by_bank[b])
			else $error("complete valid without write-back valid on bank %0d", b);
	end

	for (genvar rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin : g_rr
		// port 1 only once port 0 of that bank is taken
		a_port1_order: assert property (@(posedge CLK) disable iff (!nRST)
			read_resp_ack_by_rr[rr] && read_resp_port_by_rr[rr] |-> port0_seen_by_rr[rr])
			else $error("requester %0d got port 1 with port 0 free", rr);
	end

	// sweep plus the two pipeline stages
	a_init_quiet: assert property (@(posedge CLK) disable iff (!nRST)
		cycles_since_reset < 5'd17 |-> (last_read_resp_ack_by_rr == '0
		&& last_WB_ready_by_wr == '0))
		else $error("ack or ready seen during the init sweep");

endmodule

bind prf_wrapper prf_wrapper_chk i_chk (
	.CLK                             (CLK),
	.nRST                            (nRST),
	.read_resp_ack_by_rr             (read_resp_ack_by_rr),
	.read_resp_port_by_rr            (read_resp_port_by_rr),
	.read_req_PR_by_rr               (read_req_PR_by_rr),
	.WB_ready_by_wr                  (WB_ready_by_wr),
	.WB_PR_by_wr                     (WB_PR_by_wr),
	.last_read_resp_ack_by_rr        (last_read_resp_ack_by_rr),
	.last_WB_ready_by_wr             (last_WB_ready_by_wr),
	.last_WB_bus_valid_by_bank       (last_WB_bus_valid_by_bank),
	.last_complete_bus_valid_by_bank (last_complete_bus_valid_by_bank)
);

// File: verif/tb_prf_wrapper.sv
// prf wrapper testbench
// directed and random traffic, every output compared each cycle
// against a cycle model two cycles behind the stimulus
`timescale 1ns/1ps

module tb_prf_wrapper;

	// cycle budgets per test, the timeout is their sum plus margin
	localparam int BUDGET_INIT = 40;
	localparam int BUDGET_SINGLE = 10;
	localparam int BUDGET_CONFLICT = 24;
	localparam int BUDGET_READ_LIMIT = 10;
	localparam int BUDGET_RANDOM = 310;
	localparam int CYCLE_LIMIT = BUDGET_INIT + BUDGET_SINGLE + BUDGET_CONFLICT
		+ BUDGET_READ_LIMIT + BUDGET_RANDOM + 40;

	logic CLK;
	logic nRST;
	logic [prf_pkg::PRF_RR_COUNT-1:0] next_read_req_valid_by_rr;
	logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] next_read_req_PR_by_rr;
	logic [prf_pkg::PRF_RR_COUNT-1:0] last_read_resp_ack_by_rr;
	logic [prf_pkg::PRF_RR_COUNT-1:0] last_read_resp_port_by_rr;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::PRF_DATA_WIDTH-1:0]
		last_read_data_by_bank_by_port;
	logic [prf_pkg::PRF_WR_COUNT-1:0] next_WB_valid_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0] next_WB_send_complete_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] next_WB_data_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] next_WB_PR_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] next_WB_ROB_index_by_wr;
	logic [prf_pkg::PRF_WR_COUNT-1:0] last_WB_ready_by_wr;
	logic [prf_pkg::PRF_BANK_COUNT-1:0] last_WB_bus_valid_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] last_WB_bus_upper_PR_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] last_forward_data_bus_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0] last_complete_bus_valid_by_bank;
	logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0]
		last_complete_bus_ROB_index_by_bank;

	// expected outputs for one stimulus cycle
	typedef struct packed {
		logic [prf_pkg::PRF_RR_COUNT-1:0] ack;
		logic [prf_pkg::PRF_RR_COUNT-1:0] port;
		logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::PRF_DATA_WIDTH-1:0] rdata;
		logic [prf_pkg::PRF_WR_COUNT-1:0] ready;
		logic [prf_pkg::PRF_BANK_COUNT-1:0] wb_valid;
		logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_PRF_ROWS-1:0] upper;
		logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::PRF_DATA_WIDTH-1:0] fwd;
		logic [prf_pkg::PRF_BANK_COUNT-1:0] cv;
		logic [prf_pkg::PRF_BANK_COUNT-1:0][prf_pkg::LOG_ROB_ENTRIES-1:0] rob;
	} expect_t;

	// model state, array by register number and pointer per bank
	logic [prf_pkg::PRF_DATA_WIDTH-1:0] model_mem [prf_pkg::PR_COUNT];
	logic [prf_pkg::LOG_PRF_WR_COUNT-1:0] model_ptr [prf_pkg::PRF_BANK_COUNT];
	expect_t pending [$];
	int step;
	int cycle_count;
	int check_count;
	int error_count;
	int errors_at_start;
	int test_num;
	int seed;
	logic [prf_pkg::PRF_WR_COUNT-1:0] waiting;

	prf_wrapper i_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// --------------------------------------------------
	// compare tasks
	task automatic check_word(input string name, input logic [prf_pkg::PRF_DATA_WIDTH-1:0] exp,
		input logic [prf_pkg::PRF_DATA_WIDTH-1:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_pr(input string name, input prf_pkg::pr_index_u exp,
		input prf_pkg::pr_index_u act);
		check_count++;
		if (act.fields.upper !== exp.fields.upper) begin
			error_count++;
			$display("Fail %s: expected %h, got %h", name, exp.fields.upper, act.fields.upper);
		end
	endtask

	task automatic check_rob(input string name, input logic [prf_pkg::LOG_ROB_ENTRIES-1:0] exp,
		input logic [prf_pkg::LOG_ROB_ENTRIES-1:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// reference model, one stimulus cycle, reads before writes
	function automatic expect_t predict(input logic gated);
		expect_t e;
		prf_pkg::pr_index_u pr;
		logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0] taken;
		logic [prf_pkg::PRF_BANK_COUNT-1:0][1:0][prf_pkg::LOG_PRF_ROWS-1:0] row;
		logic granted;
		int w;
		e = '0;
		taken = '0;
		row = '0;
		// lowest requester takes port 0, next one port 1, rest lose
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			pr = next_read_req_PR_by_rr[rr];
			if (next_read_req_valid_by_rr[rr] && !gated && !taken[pr.fields.bank][1]) begin
				e.ack[rr] = 1'b1;
				e.port[rr] = taken[pr.fields.bank][0];
				row[pr.fields.bank][e.port[rr]] = pr.fields.upper;
				taken[pr.fields.bank][e.port[rr]] = 1'b1;
			end
		end
		// free ports read row 0
		for (int b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin
			for (int p = 0; p < 2; p++) begin
				pr.fields.bank = (prf_pkg::LOG_PRF_BANK_COUNT)'(b);
				pr.fields.upper = row[b][p];
				e.rdata[b][p] = model_mem[pr.raw];
			end
		end
		// first valid writer at or after the pointer wins the bank
		for (int b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin
			granted = 1'b0;
			for (int i = 0; i < prf_pkg::PRF_WR_COUNT; i++) begin
				w = (model_ptr[b] + i) % prf_pkg::PRF_WR_COUNT;
				pr = next_WB_PR_by_wr[w];
				if (!granted && !gated && next_WB_valid_by_wr[w] && pr.fields.bank == b) begin
					granted = 1'b1;
					e.ready[w] = 1'b1;
					e.wb_valid[b] = 1'b1;
					e.upper[b] = pr.fields.upper;
					e.fwd[b] = next_WB_data_by_wr[w];
					e.cv[b] = next_WB_send_complete_by_wr[w];
					e.rob[b] = next_WB_ROB_index_by_wr[w];
					model_mem[pr.raw] = next_WB_data_by_wr[w];
					model_ptr[b] = (prf_pkg::LOG_PRF_WR_COUNT)'(w + 1);
				end
			end
		end
		return e;
	endfunction

	task automatic compare_outputs(input expect_t e);
		prf_pkg::pr_index_u exp_pr;
		prf_pkg::pr_index_u act_pr;
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			check_bit($sformatf("last_read_resp_ack_by_rr[%0d]", rr), e.ack[rr],
				last_read_resp_ack_by_rr[rr]);
			if (e.ack[rr]) begin
				check_bit($sformatf("last_read_resp_port_by_rr[%0d]", rr), e.port[rr],
					last_read_resp_port_by_rr[rr]);
			end
		end
		for (int w = 0; w < prf_pkg::PRF_WR_COUNT; w++) begin
			check_bit($sformatf("last_WB_ready_by_wr[%0d]", w), e.ready[w], last_WB_ready_by_wr[w]);
		end
		for (int b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin
			for (int p = 0; p < 2; p++) begin
				check_word($sformatf("last_read_data_by_bank_by_port[%0d][%0d]", b, p),
					e.rdata[b][p], last_read_data_by_bank_by_port[b][p]);
			end
			check_bit($sformatf("last_WB_bus_valid_by_bank[%0d]", b), e.wb_valid[b],
				last_WB_bus_valid_by_bank[b]);
			exp_pr.fields.bank = (prf_pkg::LOG_PRF_BANK_COUNT)'(b);
			exp_pr.fields.upper = e.upper[b];
			act_pr.fields.bank = (prf_pkg::LOG_PRF_BANK_COUNT)'(b);
			act_pr.fields.upper = last_WB_bus_upper_PR_by_bank[b];
			check_pr($sformatf("last_WB_bus_upper_PR_by_bank[%0d]", b), exp_pr, act_pr);
			check_word($sformatf("last_forward_data_bus_by_bank[%0d]", b), e.fwd[b],
				last_forward_data_bus_by_bank[b]);
			check_bit($sformatf("last_complete_bus_valid_by_bank[%0d]", b), e.cv[b],
				last_complete_bus_valid_by_bank[b]);
			// rob index only matters with complete valid
			if (e.cv[b]) begin
				check_rob($sformatf("last_complete_bus_ROB_index_by_bank[%0d]", b), e.rob[b],
					last_complete_bus_ROB_index_by_bank[b]);
			end
		end
	endtask

	// --------------------------------------------------
	// comparing process, mid cycle where outputs are stable
	always @(negedge CLK) begin
		if (nRST !== 1'b1) begin
			pending.delete();
			step = 0;
			for (int i = 0; i < prf_pkg::PR_COUNT; i++) begin
				model_mem[i] = '0;
			end
			for (int b = 0; b < prf_pkg::PRF_BANK_COUNT; b++) begin
				model_ptr[b] = '0;
			end
		end else begin
			// two stimulus cycles in flight
			if (pending.size() == 2) begin
				compare_outputs(pending.pop_front());
			end
			// served from step 15, the core sees it once the sweep is over
			pending.push_back(predict(step < prf_pkg::PRF_ROWS - 1));
			step++;
		end
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// stimulus helpers
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic clear_inputs();
		next_read_req_valid_by_rr = '0;
		next_read_req_PR_by_rr = '0;
		next_WB_valid_by_wr = '0;
		next_WB_send_complete_by_wr = '0;
		next_WB_data_by_wr = '0;
		next_WB_PR_by_wr = '0;
		next_WB_ROB_index_by_wr = '0;
	endtask

	task automatic set_read(input int rr, input int pr);
		next_read_req_valid_by_rr[rr] = 1'b1;
		next_read_req_PR_by_rr[rr] = (prf_pkg::LOG_PR_COUNT)'(pr);
	endtask

	task automatic set_write(input int w, input int pr,
		input logic [prf_pkg::PRF_DATA_WIDTH-1:0] data, input logic complete, input int rob);
		next_WB_valid_by_wr[w] = 1'b1;
		next_WB_PR_by_wr[w] = (prf_pkg::LOG_PR_COUNT)'(pr);
		next_WB_data_by_wr[w] = data;
		next_WB_send_complete_by_wr[w] = complete;
		next_WB_ROB_index_by_wr[w] = (prf_pkg::LOG_ROB_ENTRIES)'(rob);
	endtask

	// drain the pipeline and report the test
	task automatic end_test(input string name);
		next_cycle();
		clear_inputs();
		repeat (3) next_cycle();
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	// --------------------------------------------------
	// test sequence
	initial begin
		seed = 55;
		cycle_count = 0;
		check_count = 0;
		error_count = 0;
		errors_at_start = 0;
		test_num = 0;
		nRST = 1'b0;
		clear_inputs();
		repeat (2) @(posedge CLK);
		#1;
		compare_outputs('0);
		@(posedge CLK);
		#1;
		nRST = 1'b1;

		// every requester busy through the sweep, nothing granted
		for (int i = 0; i < prf_pkg::PRF_ROWS - 1; i++) begin
			for (int k = 0; k < prf_pkg::PRF_WR_COUNT; k++) begin
				set_read(k, 5 * k + i);
				set_write(k, 17 * k, $random(seed), 1'b1, k);
			end
			next_cycle();
		end
		// all 64 registers read back as zero
		for (int row = 0; row < prf_pkg::PRF_ROWS; row++) begin
			clear_inputs();
			for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
				set_read(rr, 4 * row + rr);
			end
			next_cycle();
		end
		end_test("reset and init");

		// write with complete, then without, each read right after
		set_write(2, 37, 32'hcafe_0137, 1'b1, 19);
		next_cycle();
		clear_inputs();
		set_write(0, 22, 32'h1234_5022, 1'b0, 7);
		set_read(0, 37);
		next_cycle();
		clear_inputs();
		set_read(1, 22);
		set_read(3, 37);
		end_test("single write then read");

		// four writers on bank 2, losers retry until all land
		for (int pass = 0; pass < 2; pass++) begin
			waiting = '1;
			while (waiting != '0) begin
				clear_inputs();
				for (int w = 0; w < prf_pkg::PRF_WR_COUNT; w++) begin
					if (waiting[w]) begin
						set_write(w, 4 * (w + 4) + 2, 32'h5a5a_0000 | 32'(pass * 16 + w), w[0], w + 8);
					end
				end
				next_cycle();
				clear_inputs();
				next_cycle();
				// ready of that round is on the outputs now
				check_bit("onehot last_WB_ready_by_wr", 1'b1, $onehot(last_WB_ready_by_wr));
				waiting = waiting & ~last_WB_ready_by_wr;
			end
		end
		end_test("write conflict");

		// four readers on one bank, then spread and the leftover pair
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			set_read(rr, 18 + 4 * rr);
		end
		next_cycle();
		for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
			set_read(rr, 20 + rr);
		end
		next_cycle();
		clear_inputs();
		set_read(2, 26);
		set_read(3, 30);
		end_test("read port limit");

		// random mixed traffic
		for (int i = 0; i < 300; i++) begin
			next_read_req_valid_by_rr = (prf_pkg::PRF_RR_COUNT)'($random(seed));
			next_WB_valid_by_wr = (prf_pkg::PRF_WR_COUNT)'($random(seed));
			next_WB_send_complete_by_wr = (prf_pkg::PRF_WR_COUNT)'($random(seed));
			for (int k = 0; k < prf_pkg::PRF_WR_COUNT; k++) begin
				next_read_req_PR_by_rr[k] = (prf_pkg::LOG_PR_COUNT)'($random(seed));
				next_WB_PR_by_wr[k] = (prf_pkg::LOG_PR_COUNT)'($random(seed));
				next_WB_data_by_wr[k] = $random(seed);
				next_WB_ROB_index_by_wr[k] = (prf_pkg::LOG_ROB_ENTRIES)'($random(seed));
			end
			next_cycle();
		end
		end_test("random traffic");

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
